// File: list.f
+incdir+include
hdl/eth_mac_pkg.sv
hdl/crc32_d8.sv
hdl/frame_fifo.sv
hdl/gmii_tx_framer.sv
hdl/gmii_rx_deframer.sv
hdl/eth_mac_gmii.sv
sim/eth_mac_gmii_assert.sv
sim/eth_mac_gmii_tb.sv

// File: sim/eth_mac_gmii_tb.sv
`timescale 1ns/10ps
`include "eth_mac_defines.svh"

module eth_mac_gmii_tb;
	import eth_mac_pkg::*;

	localparam logic [47:0] STATION_MAC = 48'h02005e102030;
	localparam logic [47:0] FOREIGN_MAC = 48'h021122334455;
	localparam logic [47:0] BCAST_MAC = 48'hffffffffffff;
	localparam logic [47:0] SRC_MAC = 48'h02aabbccdd01;
	localparam logic [31:0] LFSR_TAPS = 32'hb4bcd35c;
	// payload byte j is on the wire this many cycles after tx_en rises
	localparam int PAY_OFFSET = `ETH_PREAMBLE_LEN + 14;
	localparam int CORRUPT_FRAME = 4;
	localparam int CORRUPT_BYTE = 17;
	localparam logic [7:0] CORRUPT_MASK = 8'h08;
	// five frames of at most 139 cycles each plus drains and a wide margin
	localparam int MAX_CYCLES = 4000;

	logic clk;
	logic reset;
	logic [47:0] station_mac;
	logic hdr_valid;
	eth_header_t hdr;
	logic hdr_credit;
	logic pay_valid;
	tx_byte_t pay;
	logic pay_credit;
	gmii_tx_t gmii_tx;
	gmii_rx_t gmii_rx = '0;
	logic rx_valid;
	rx_byte_t rx;

	logic [31:0] lfsr_state;
	int hdr_credits;
	int pay_credits;
	int errors = 0;
	int cycle_cnt = 0;
	rx_byte_t exp_q [$];
	rx_byte_t exp_b;
	int tx_frame = -1;
	int tx_pos = 0;
	logic tx_en_d = 1'b0;
	logic [7:0] flip;

	eth_mac_gmii dut (
		.clk(clk),
		.reset(reset),
		.station_mac(station_mac),
		.hdr_valid(hdr_valid),
		.hdr(hdr),
		.hdr_credit(hdr_credit),
		.pay_valid(pay_valid),
		.pay(pay),
		.pay_credit(pay_credit),
		.gmii_tx(gmii_tx),
		.gmii_rx(gmii_rx),
		.rx_valid(rx_valid),
		.rx(rx)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Errors: %0d testbench, %0d bound assertion", errors, dut.mac_chk.failures);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// every wait goes through here so no credit pulse is missed
	task automatic next_cycle();
		@(negedge clk);
		hdr_valid = 1'b0;
		pay_valid = 1'b0;
		if (hdr_credit)
			hdr_credits++;
		if (pay_credit)
			pay_credits++;
	endtask

	task automatic send_frame(input logic [47:0] dmac, input int len, input int flip_at);
		logic [7:0] data [$];
		logic [7:0] b;
		rx_byte_t e;
		int n_rx;
		for (int i = 0; i < len; i++) begin
			rand_byte(b);
			data.push_back(b);
		end
		// only frames that pass the address filter come back
		if ((dmac == station_mac) || (dmac == BCAST_MAC)) begin
			n_rx = (len < `ETH_MIN_PAYLOAD) ? `ETH_MIN_PAYLOAD : len;
			for (int i = 0; i < n_rx; i++) begin
				if (i < len)
					e.data = data[i];
				else
					e.data = 8'h00;
				if (i == flip_at)
					e.data = e.data ^ CORRUPT_MASK;
				e.last = (i == n_rx - 1);
				e.crc_err = e.last && (flip_at >= 0);
				exp_q.push_back(e);
			end
		end
		while (hdr_credits == 0)
			next_cycle();
		hdr.dmac = dmac;
		hdr.smac = SRC_MAC;
		hdr.ethertype = 16'h88b5;
		hdr_valid = 1'b1;
		hdr_credits--;
		next_cycle();
		for (int i = 0; i < len; i++) begin
			while (pay_credits == 0)
				next_cycle();
			pay.data = data[i];
			pay.last = (i == len - 1);
			pay_valid = 1'b1;
			pay_credits--;
			next_cycle();
		end
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			next_cycle();
		repeat (2 * `ETH_GAP_LEN)
			next_cycle();
	endtask

	// loopback with a single bit flip in one chosen frame
	always @(negedge clk) begin
		if (reset !== 1'b0) begin
			gmii_rx <= '0;
		end else begin
			if (gmii_tx.tx_en && !tx_en_d) begin
				tx_frame = tx_frame + 1;
				tx_pos = 0;
			end else if (gmii_tx.tx_en) begin
				tx_pos = tx_pos + 1;
			end
			tx_en_d = gmii_tx.tx_en;
			flip = 8'h00;
			if ((tx_frame == CORRUPT_FRAME) && (tx_pos == PAY_OFFSET + CORRUPT_BYTE))
				flip = CORRUPT_MASK;
			gmii_rx.rxd <= gmii_tx.txd ^ flip;
			gmii_rx.rx_dv <= gmii_tx.tx_en;
			gmii_rx.rx_er <= gmii_tx.tx_er;
		end
	end

	always @(negedge clk) begin
		if (!reset && rx_valid) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Error at %0t: byte %h received while none was expected",
					$time, rx.data);
			end
			if (exp_q.size() != 0) begin
				exp_b = exp_q.pop_front();
				assert (rx.data == exp_b.data) else begin
					errors++;
					$display("Error at %0t: rx data %h, expected %h", $time, rx.data, exp_b.data);
				end
				assert (rx.last == exp_b.last) else begin
					errors++;
					$display("Error at %0t: rx last %b, expected %b", $time, rx.last, exp_b.last);
				end
				// crc_err counts on the last byte only
				assert (!rx.last || (rx.crc_err == exp_b.crc_err)) else begin
					errors++;
					$display("Error at %0t: crc_err %b, expected %b",
						$time, rx.crc_err, exp_b.crc_err);
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		station_mac = STATION_MAC;
		hdr_valid = 1'b0;
		hdr = '0;
		pay_valid = 1'b0;
		pay = '0;
		lfsr_state = 32'd43;
		hdr_credits = `ETH_HDR_DEPTH;
		pay_credits = `ETH_PAY_DEPTH;
		repeat (16)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		next_cycle();

		// short padded frame then a long one back to back
		send_frame(STATION_MAC, 10, -1);
		send_frame(STATION_MAC, 100, -1);
		wait_drained();

		send_frame(FOREIGN_MAC, 50, -1);
		send_frame(BCAST_MAC, 30, -1);
		wait_drained();

		send_frame(STATION_MAC, 60, CORRUPT_BYTE);
		wait_drained();

		assert (hdr_credits == `ETH_HDR_DEPTH) else begin
			errors++;
			$display("Error at %0t: header credits %0d after the run, expected %0d",
				$time, hdr_credits, `ETH_HDR_DEPTH);
		end
		assert (pay_credits == `ETH_PAY_DEPTH) else begin
			errors++;
			$display("Error at %0t: payload credits %0d after the run, expected %0d",
				$time, pay_credits, `ETH_PAY_DEPTH);
		end

		$display("Errors: %0d testbench, %0d bound assertion", errors, dut.mac_chk.failures);
		if ((errors == 0) && (dut.mac_chk.failures == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: sim/eth_mac_gmii_assert.sv
`timescale 1ns/10ps
`include "eth_mac_defines.svh"

module eth_mac_gmii_assert (
	input  logic                  clk,
	input  logic                  reset,
	input  eth_mac_pkg::gmii_tx_t gmii_tx,
	input  logic                  hdr_valid,
	input  logic                  hdr_credit,
	input  logic                  pay_valid,
	input  logic                  pay_credit,
	input  logic                  pay_pop
);
	localparam int HDR_LEN = 14;

	int failures = 0;
	int on_cnt;
	int low_cnt;
	int pay_cnt;
	int hdr_out;
	int pay_out;
	int exp_len;
	logic tx_en;
	logic tx_er;
	logic [7:0] txd;

	assign tx_en = gmii_tx.tx_en;
	assign tx_er = gmii_tx.tx_er;
	assign txd = gmii_tx.txd;
	// short payloads are padded up to the minimum
	assign exp_len = `ETH_PREAMBLE_LEN + HDR_LEN + `ETH_FCS_LEN
		+ ((pay_cnt > `ETH_MIN_PAYLOAD) ? pay_cnt : `ETH_MIN_PAYLOAD);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			on_cnt <= 0;
			low_cnt <= `ETH_GAP_LEN;
			pay_cnt <= 0;
			hdr_out <= 0;
			pay_out <= 0;
		end else begin
			on_cnt <= tx_en ? on_cnt + 1 : 0;
			if (tx_en)
				low_cnt <= 0;
			else if (low_cnt < `ETH_GAP_LEN)
				low_cnt <= low_cnt + 1;
			pay_cnt <= tx_en ? pay_cnt + int'(pay_pop) : 0;
			// entries in flight that have not come back as credits
			hdr_out <= hdr_out + int'(hdr_valid) - int'(hdr_credit);
			pay_out <= pay_out + int'(pay_valid) - int'(pay_credit);
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		tx_en && (on_cnt < `ETH_PREAMBLE_LEN - 1) |-> (txd == `ETH_PREAMBLE))
	else begin
		failures++;
		$error("preamble byte is not 0x55");
	end

	assert property (@(posedge clk) disable iff (reset)
		tx_en && (on_cnt == `ETH_PREAMBLE_LEN - 1) |-> (txd == `ETH_SFD))
	else begin
		failures++;
		$error("eighth byte of the frame is not the SFD");
	end

	assert property (@(posedge clk) disable iff (reset)
		tx_en && (on_cnt == 0) |-> (low_cnt >= `ETH_GAP_LEN))
	else begin
		failures++;
		$error("inter-frame gap shorter than 12 cycles");
	end

	// first idle cycle after a frame
	assert property (@(posedge clk) disable iff (reset)
		!tx_en && (on_cnt != 0) |-> (on_cnt == exp_len))
	else begin
		failures++;
		$error("tx_en high for the wrong number of cycles");
	end

	assert property (@(posedge clk) disable iff (reset) !tx_er)
	else begin
		failures++;
		$error("tx_er raised");
	end

	// a negative tally is a credit for an entry never pushed
	assert property (@(posedge clk) disable iff (reset)
		(hdr_out >= 0) && (hdr_out <= `ETH_HDR_DEPTH))
	else begin
		failures++;
		$error("header credits out of balance with header pushes");
	end

	assert property (@(posedge clk) disable iff (reset)
		(pay_out >= 0) && (pay_out <= `ETH_PAY_DEPTH))
	else begin
		failures++;
		$error("payload credits out of balance with payload pushes");
	end

endmodule

bind eth_mac_gmii eth_mac_gmii_assert mac_chk (
	.clk(clk),
	.reset(reset),
	.gmii_tx(gmii_tx),
	.hdr_valid(hdr_valid),
	.hdr_credit(hdr_credit),
	.pay_valid(pay_valid),
	.pay_credit(pay_credit),
	.pay_pop(pay_pop)
);

// File: hdl/eth_mac_gmii.sv
`timescale 1ns/10ps
`include "eth_mac_defines.svh"

module eth_mac_gmii (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [47:0]              station_mac,
	input  logic                     hdr_valid,
	input  eth_mac_pkg::eth_header_t hdr,
	output logic                     hdr_credit,
	input  logic                     pay_valid,
	input  eth_mac_pkg::tx_byte_t    pay,
	output logic                     pay_credit,
	output eth_mac_pkg::gmii_tx_t    gmii_tx,
	input  eth_mac_pkg::gmii_rx_t    gmii_rx,
	output logic                     rx_valid,
	output eth_mac_pkg::rx_byte_t    rx
);
	import eth_mac_pkg::*;

	eth_header_t hdr_head;
	logic hdr_ready;
	logic hdr_pop;
	tx_byte_t pay_head;
	logic pay_ready;
	logic pay_pop;

	frame_fifo #(
		.entry_t(eth_header_t),
		.DEPTH(`ETH_HDR_DEPTH)
	) hdr_q (
		.clk(clk),
		.reset(reset),
		.push(hdr_valid),
		.din(hdr),
		.pop(hdr_pop),
		.dout(hdr_head),
		.not_empty(hdr_ready),
		.credit(hdr_credit)
	);

	frame_fifo #(
		.entry_t(tx_byte_t),
		.DEPTH(`ETH_PAY_DEPTH)
	) pay_q (
		.clk(clk),
		.reset(reset),
		.push(pay_valid),
		.din(pay),
		.pop(pay_pop),
		.dout(pay_head),
		.not_empty(pay_ready),
		.credit(pay_credit)
	);

	gmii_tx_framer framer (
		.clk(clk),
		.reset(reset),
		.hdr(hdr_head),
		.hdr_ready(hdr_ready),
		.hdr_pop(hdr_pop),
		.pay(pay_head),
		.pay_ready(pay_ready),
		.pay_pop(pay_pop),
		.gmii_tx(gmii_tx)
	);

	gmii_rx_deframer deframer (
		.clk(clk),
		.reset(reset),
		.station_mac(station_mac),
		.gmii_rx(gmii_rx),
		.rx_valid(rx_valid),
		.rx(rx)
	);

endmodule

// File: hdl/gmii_rx_deframer.sv
`timescale 1ns/10ps
`include "eth_mac_defines.svh"

module gmii_rx_deframer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [47:0]           station_mac,
	input  eth_mac_pkg::gmii_rx_t gmii_rx,
	output logic                  rx_valid,
	output eth_mac_pkg::rx_byte_t rx
);
	import eth_mac_pkg::*;

	localparam int HDR_BITS = $bits(eth_header_t);
	localparam int HDR_LEN = HDR_BITS / 8;
	// last payload byte plus the FCS
	localparam int DLY = `ETH_FCS_LEN + 1;
	localparam int FW = $clog2(DLY + 1);

	typedef enum logic [2:0] {
		st_idle,
		st_hunt,
		st_header,
		st_payload,
		st_gap
	} state_t;

	state_t state;
	gmii_rx_t in_r;
	logic dv_d;
	logic [3:0] cnt;
	eth_header_t hdr_sr;
	logic [DLY-1:0][7:0] dly;
	logic [FW-1:0] fill;
	logic er_seen;
	logic accept;
	logic crc_en;
	logic residue_ok;

	assign accept = (hdr_sr.dmac == station_mac) || (&hdr_sr.dmac);
	assign crc_en = in_r.rx_dv && ((state == st_header) || (state == st_payload));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			in_r <= '0;
			dv_d <= 1'b0;
		end else begin
			in_r <= gmii_rx;
			dv_d <= in_r.rx_dv;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			fill <= '0;
			er_seen <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (in_r.rx_dv && !dv_d)
						state <= st_hunt;
				end
				st_hunt: begin
					cnt <= '0;
					fill <= '0;
					er_seen <= 1'b0;
					if (!in_r.rx_dv)
						state <= st_idle;
					else if (in_r.rxd == `ETH_SFD)
						state <= st_header;
				end
				st_header: begin
					if (!in_r.rx_dv) begin
						// runt frame so wait out the gap
						state <= st_gap;
						cnt <= '0;
					end else begin
						er_seen <= er_seen | in_r.rx_er;
						cnt <= cnt + 1'b1;
						if (cnt == HDR_LEN - 1) begin
							state <= st_payload;
							cnt <= '0;
						end
					end
				end
				st_payload: begin
					if (in_r.rx_dv) begin
						er_seen <= er_seen | in_r.rx_er;
						if (fill != DLY)
							fill <= fill + 1'b1;
						else
							rx_valid <= accept;
					end else begin
						rx_valid <= accept && (fill == DLY);
						state <= st_gap;
						cnt <= '0;
					end
				end
				st_gap: begin
					cnt <= cnt + 1'b1;
					if (cnt == `ETH_GAP_LEN - 1)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_header) && in_r.rx_dv)
			hdr_sr <= {hdr_sr[HDR_BITS-9:0], in_r.rxd};
		if ((state == st_payload) && in_r.rx_dv)
			dly <= {dly[DLY-2:0], in_r.rxd};
		// head of the delay line is the last payload byte once dv drops
		if (state == st_payload) begin
			rx.data <= dly[DLY-1];
			rx.last <= !in_r.rx_dv;
			rx.crc_err <= !in_r.rx_dv && (!residue_ok || er_seen);
		end
	end

	crc32_d8 rx_crc (
		.clk(clk),
		.reset(reset),
		.clear(state == st_hunt),
		.en(crc_en),
		.d(in_r.rxd),
		.crc(),
		.residue_ok(residue_ok)
	);

endmodule

// File: hdl/gmii_tx_framer.sv
`timescale 1ns/10ps
`include "eth_mac_defines.svh"

module gmii_tx_framer (
	input  logic                     clk,
	input  logic                     reset,
	input  eth_mac_pkg::eth_header_t hdr,
	input  logic                     hdr_ready,
	output logic                     hdr_pop,
	input  eth_mac_pkg::tx_byte_t    pay,
	input  logic                     pay_ready,
	output logic                     pay_pop,
	output eth_mac_pkg::gmii_tx_t    gmii_tx
);
	import eth_mac_pkg::*;

	localparam int HDR_BITS = $bits(eth_header_t);
	localparam int HDR_LEN = HDR_BITS / 8;

	typedef enum logic [2:0] {
		st_idle,
		st_preamble,
		st_header,
		st_payload,
		st_pad,
		st_fcs,
		st_gap
	} state_t;

	state_t state;
	state_t state_nx;
	logic [10:0] cnt;
	logic [10:0] cnt_nx;
	logic [HDR_BITS-1:0] hdr_sr;
	logic underrun;
	logic [7:0] txd;
	logic [31:0] crc;
	logic crc_en;

	always_comb begin
		state_nx = state;
		cnt_nx = cnt + 1'b1;
		case (state)
			st_idle: begin
				cnt_nx = '0;
				if (hdr_ready && pay_ready)
					state_nx = st_preamble;
			end
			st_preamble: begin
				if (cnt == `ETH_PREAMBLE_LEN - 1) begin
					state_nx = st_header;
					cnt_nx = '0;
				end
			end
			st_header: begin
				if (cnt == HDR_LEN - 1) begin
					state_nx = st_payload;
					cnt_nx = '0;
				end
			end
			st_payload: begin
				// counter runs on into pad so it totals the payload bytes
				if (pay_ready && pay.last) begin
					if (cnt >= `ETH_MIN_PAYLOAD - 1) begin
						state_nx = st_fcs;
						cnt_nx = '0;
					end else begin
						state_nx = st_pad;
					end
				end
			end
			st_pad: begin
				if (cnt == `ETH_MIN_PAYLOAD - 1) begin
					state_nx = st_fcs;
					cnt_nx = '0;
				end
			end
			st_fcs: begin
				if (cnt == `ETH_FCS_LEN - 1) begin
					state_nx = st_gap;
					cnt_nx = '0;
				end
			end
			st_gap: begin
				if (cnt == `ETH_GAP_LEN - 1) begin
					state_nx = st_idle;
					cnt_nx = '0;
				end
			end
			default: state_nx = st_idle;
		endcase
	end

	always_comb begin
		case (state)
			st_preamble: txd = (cnt == `ETH_PREAMBLE_LEN - 1) ? `ETH_SFD : `ETH_PREAMBLE;
			st_header: txd = hdr_sr[HDR_BITS-1 -: 8];
			st_payload: txd = pay_ready ? pay.data : 8'h00;
			st_fcs: txd = crc[8*cnt[1:0] +: 8];
			default: txd = 8'h00;
		endcase
	end

	assign hdr_pop = (state == st_preamble) && (cnt == `ETH_PREAMBLE_LEN - 1);
	assign pay_pop = (state == st_payload) && pay_ready;
	assign crc_en = (state == st_header) || (state == st_payload) || (state == st_pad);

	assign gmii_tx.txd = txd;
	assign gmii_tx.tx_en = (state != st_idle) && (state != st_gap);
	// underrun poisons the rest of the payload
	assign gmii_tx.tx_er = (state == st_payload) && (underrun || !pay_ready);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			underrun <= 1'b0;
		end else begin
			state <= state_nx;
			cnt <= cnt_nx;
			if (state == st_idle)
				underrun <= 1'b0;
			else if ((state == st_payload) && !pay_ready)
				underrun <= 1'b1;
		end
	end

	// loaded on the SFD, msb byte first on the wire
	always_ff @(posedge clk) begin
		if (hdr_pop)
			hdr_sr <= hdr;
		else if (state == st_header)
			hdr_sr <= {hdr_sr[HDR_BITS-9:0], 8'h00};
	end

	crc32_d8 tx_crc (
		.clk(clk),
		.reset(reset),
		.clear(state == st_preamble),
		.en(crc_en),
		.d(txd),
		.crc(crc),
		.residue_ok()
	);

endmodule

// File: hdl/frame_fifo.sv
`timescale 1ns/10ps

module frame_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   push,
	input  entry_t din,
	input  logic   pop,
	output entry_t dout,
	output logic   not_empty,
	output logic   credit
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_push;
	logic do_pop;

	assign not_empty = (count != '0);
	assign do_pop = pop && not_empty;
	// a push into a full queue is dropped
	assign do_push = push && (count != DEPTH);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= do_pop;
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/crc32_d8.sv
`timescale 1ns/10ps

module crc32_d8 (
	input  logic        clk,
	input  logic        reset,
	input  logic        clear,
	input  logic        en,
	input  logic [7:0]  d,
	output logic [31:0] crc,
	output logic        residue_ok
);
	localparam logic [31:0] POLY = 32'hedb88320;
	localparam logic [31:0] RESIDUE = 32'hdebb20e3;

	logic [31:0] crc_r;
	logic [31:0] crc_nx;

	// lsb first, one data bit per step
	always_comb begin
		crc_nx = crc_r;
		for (int i = 0; i < 8; i++) begin
			if (crc_nx[0] ^ d[i])
				crc_nx = (crc_nx >> 1) ^ POLY;
			else
				crc_nx = crc_nx >> 1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			crc_r <= '1;
		else if (clear)
			crc_r <= '1;
		else if (en)
			crc_r <= crc_nx;
	end

	assign crc = ~crc_r;
	assign residue_ok = (crc_r == RESIDUE);

endmodule

// File: hdl/eth_mac_pkg.sv
package eth_mac_pkg;

	// 14 header bytes, dmac goes out first
	typedef struct packed {
		logic [47:0] dmac;
		logic [47:0] smac;
		logic [15:0] ethertype;
	} eth_header_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} tx_byte_t;

	// crc_err only meaningful together with last
	typedef struct packed {
		logic [7:0] data;
		logic last;
		logic crc_err;
	} rx_byte_t;

	typedef struct packed {
		logic [7:0] txd;
		logic tx_en;
		logic tx_er;
	} gmii_tx_t;

	typedef struct packed {
		logic [7:0] rxd;
		logic rx_dv;
		logic rx_er;
	} gmii_rx_t;

endpackage

// File: include/eth_mac_defines.svh
`ifndef ETH_MAC_DEFINES_SVH
`define ETH_MAC_DEFINES_SVH

// queue depths and the initial credit counts
`define ETH_HDR_DEPTH 2
`define ETH_PAY_DEPTH 64

// shorter payloads get zero padding up to this
`define ETH_MIN_PAYLOAD 46

// preamble length counts the SFD
`define ETH_PREAMBLE_LEN 8
`define ETH_GAP_LEN 12
`define ETH_FCS_LEN 4

`define ETH_PREAMBLE 8'h55
`define ETH_SFD 8'hd5

`endif
